/* hw/rate_servo_pkg.sv */
package rate_servo_pkg;

    //////////////////////////////
    // Widths
    localparam int WB_ADR_W = 22;            // Trigger and CSR address width
    localparam int WB_DAT_W = 32;
    localparam int WB_SEL_W = WB_DAT_W / 8;  // One select bit per byte lane
    localparam int THRESH_W = 18;            // Trigger threshold field
    localparam int BEAM_W   = 8;             // Beam index, low address byte

    localparam logic [THRESH_W-1:0] THRESH_MAX = '1;  // Saturation ceiling

    //////////////////////////////
    // Trigger address map
    localparam logic [WB_ADR_W-1:0] TRIG_CTRL_ADR  = 22'h000;  // Command and status word
    localparam logic [WB_ADR_W-1:0] TRIG_BEAM_BASE = 22'h100;  // Count on read, threshold on write
    localparam logic [WB_ADR_W-1:0] TRIG_CE_BASE   = 22'h200;  // Per-beam threshold enable

    // Software register map
    localparam int CSR_COUNT_BIT  = 8;   // Last measured counts
    localparam int CSR_THRESH_BIT = 9;   // Current thresholds
    localparam int CSR_TARGET_BIT = 0;   // Set for target, clear for K_P

    // Command words written to TRIG_CTRL_ADR
    typedef enum logic [WB_DAT_W-1:0] {
        CMD_START  = 32'd1,  // Begin a counting period
        CMD_UPDATE = 32'd2   // Load all enabled thresholds at once
    } trig_cmd_e;

    typedef enum logic [2:0] {
        BOOT, START, POLL, READ_COUNTS, STEP, WRITE_THRESH, APPLY, UPDATE
    } loop_state_e;

    typedef enum logic [1:0] {
        IDLE, READ, WRITE, ACK
    } csr_state_e;

    // Wishbone classic request, master to slave
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
        logic [WB_SEL_W-1:0] sel;
    } wb_req_t;

    // One trigger access, sequencer to bus master
    typedef struct packed {
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } trig_cmd_t;

endpackage

/* hw/servo_csr_slave.sv */
module servo_csr_slave #(
    parameter int NBEAMS       = 4,
    parameter int START_KP     = 1,
    parameter int START_TARGET = 100
) (
    input  logic                                            wb_clk_i,
    input  logic                                            arst_n_i,
    input  logic                                            wb_cyc_i,
    input  logic                                            wb_stb_i,
    input  logic                                            wb_we_i,
    input  logic [rate_servo_pkg::WB_ADR_W-1:0]             wb_adr_i,
    input  logic [rate_servo_pkg::WB_DAT_W-1:0]             wb_dat_i,
    input  logic [rate_servo_pkg::WB_SEL_W-1:0]             wb_sel_i,
    input  logic [NBEAMS-1:0][rate_servo_pkg::WB_DAT_W-1:0] counts_i,
    input  logic [NBEAMS-1:0][rate_servo_pkg::THRESH_W-1:0] thresh_i,
    output logic                                            wb_ack_o,
    output logic [rate_servo_pkg::WB_DAT_W-1:0]             wb_dat_o,
    output logic [rate_servo_pkg::WB_DAT_W-1:0]             kp_o,
    output logic [rate_servo_pkg::WB_DAT_W-1:0]             target_o
);
    import rate_servo_pkg::*;

    csr_state_e          state_q;
    logic [WB_DAT_W-1:0] resp_q;      // Read data, held through ACK
    logic [WB_DAT_W-1:0] kp_q;
    logic [WB_DAT_W-1:0] target_q;
    logic [BEAM_W-1:0]   beam;
    logic                beam_ok;     // Index lands on a real beam
    logic                loop_reg;    // Neither count nor threshold space

    assign beam     = wb_adr_i[BEAM_W-1:0];
    assign beam_ok  = beam < NBEAMS;
    assign loop_reg = !wb_adr_i[CSR_COUNT_BIT] && !wb_adr_i[CSR_THRESH_BIT];

    //////////////////////////////
    // Request FSM
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= IDLE;
            kp_q     <= WB_DAT_W'(START_KP);
            target_q <= WB_DAT_W'(START_TARGET);
        end else begin
            unique case (state_q)
                IDLE:        if (wb_cyc_i && wb_stb_i) state_q <= wb_we_i ? WRITE : READ;
                READ, WRITE: state_q <= ACK;
                ACK:         state_q <= IDLE;   // Master drops stb after ack
                default:     state_q <= IDLE;
            endcase
            // Byte-lane write to the loop registers only
            if (state_q == WRITE && loop_reg) begin
                for (int b = 0; b < WB_SEL_W; b++) begin
                    if (wb_sel_i[b] && wb_adr_i[CSR_TARGET_BIT])
                        target_q[8*b +: 8] <= wb_dat_i[8*b +: 8];
                    else if (wb_sel_i[b])
                        kp_q[8*b +: 8] <= wb_dat_i[8*b +: 8];
                end
            end
        end
    end

    // Read response, loaded in READ
    always_ff @(posedge wb_clk_i) begin
        if (state_q == READ) begin
            if (wb_adr_i[CSR_COUNT_BIT])
                resp_q <= beam_ok ? counts_i[beam] : '0;
            else if (wb_adr_i[CSR_THRESH_BIT])
                resp_q <= beam_ok ? WB_DAT_W'(thresh_i[beam]) : '0;  // Zero-extended
            else
                resp_q <= wb_adr_i[CSR_TARGET_BIT] ? target_q : kp_q;
        end
    end

    assign wb_ack_o = (state_q == ACK);
    assign wb_dat_o = resp_q;
    assign kp_o     = kp_q;
    assign target_o = target_q;

    // Single-cycle ack, so a held request is never acked twice
    a_ack_pulse : assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

/* hw/rate_loop_seq.sv */
module rate_loop_seq #(
    parameter int NBEAMS      = 4,
    parameter int BOOT_CYCLES = 31
) (
    input  logic                                wb_clk_i,
    input  logic                                arst_n_i,
    input  logic                                cmd_done_i,
    input  logic [rate_servo_pkg::WB_DAT_W-1:0] rsp_dat_i,
    input  logic [rate_servo_pkg::THRESH_W-1:0] next_thresh_i,
    output logic                                cmd_valid_o,
    output rate_servo_pkg::trig_cmd_t           cmd_o,
    output logic [rate_servo_pkg::BEAM_W-1:0]   beam_idx_o,
    output logic                                count_we_o,
    output logic                                step_en_o,
    output logic                                commit_o
);
    import rate_servo_pkg::*;

    localparam int BOOT_W = $clog2(BOOT_CYCLES) + 1;

    loop_state_e       state_q;
    logic [BEAM_W-1:0] beam_q;
    logic [BOOT_W-1:0] boot_q;      // Boot delay, counts down to zero
    logic              beam_last;   // Current beam is the highest one
    logic              beam_step;   // Advance to the next beam this cycle
    logic              beam_state;  // States that walk the beams over the bus

    assign beam_last  = (beam_q == BEAM_W'(NBEAMS - 1));
    assign beam_state = state_q inside {WRITE_THRESH, APPLY, READ_COUNTS};
    assign beam_step  = (beam_state && cmd_done_i) || state_q == STEP;

    //////////////////////////////
    // Loop FSM
    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= BOOT;
            beam_q  <= '0;
            boot_q  <= BOOT_W'(BOOT_CYCLES - 1);
        end else begin
            if (beam_step) beam_q <= beam_last ? '0 : beam_q + 1'b1;
            if (state_q == BOOT && boot_q != '0) boot_q <= boot_q - 1'b1;

            unique case (state_q)
                BOOT:         if (boot_q == '0) state_q <= WRITE_THRESH;
                WRITE_THRESH: if (beam_step && beam_last) state_q <= APPLY;
                APPLY:        if (beam_step && beam_last) state_q <= UPDATE;
                UPDATE:       if (cmd_done_i) state_q <= START;
                START:        if (cmd_done_i) state_q <= POLL;
                POLL:         if (cmd_done_i && rsp_dat_i[0]) state_q <= READ_COUNTS;  // Period over
                READ_COUNTS:  if (beam_step && beam_last) state_q <= STEP;
                STEP:         if (beam_last) state_q <= WRITE_THRESH;   // One beam per cycle
                default:      state_q <= BOOT;
            endcase
        end
    end

    // Command for the current state and beam
    always_comb begin
        cmd_o = '{we: 1'b1, adr: TRIG_CTRL_ADR, dat: '0};
        unique case (state_q)
            START:  cmd_o.dat = CMD_START;
            UPDATE: cmd_o.dat = CMD_UPDATE;
            POLL:   cmd_o.we  = 1'b0;           // Status read, bit 0 is done
            READ_COUNTS: begin
                cmd_o.we  = 1'b0;
                cmd_o.adr = TRIG_BEAM_BASE + WB_ADR_W'(beam_q);
            end
            WRITE_THRESH: begin
                cmd_o.adr = TRIG_BEAM_BASE + WB_ADR_W'(beam_q);
                cmd_o.dat = WB_DAT_W'(next_thresh_i);
            end
            APPLY: begin
                cmd_o.adr = TRIG_CE_BASE + WB_ADR_W'(beam_q);
                cmd_o.dat = WB_DAT_W'(1);       // Enable this beam's new threshold
            end
            default: ;
        endcase
    end

    // Every state but BOOT and STEP talks to the trigger
    assign cmd_valid_o = !(state_q inside {BOOT, STEP});
    assign beam_idx_o  = beam_q;
    assign count_we_o  = (state_q == READ_COUNTS) && cmd_done_i;
    assign step_en_o   = (state_q == STEP);
    assign commit_o    = (state_q == UPDATE) && cmd_done_i;  // Trigger took the update

    // Master latches cmd_o once; it must hold until the access is over
    a_cmd_stable : assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        (cmd_valid_o && !cmd_done_i) |=> (cmd_o == $past(cmd_o)));

endmodule

/* hw/threshold_bank.sv */
module threshold_bank #(
    parameter int NBEAMS       = 4,
    parameter int START_THRESH = 3500,
    parameter int COUNT_MARGIN = 10
) (
    input  logic                                            wb_clk_i,
    input  logic                                            arst_n_i,
    input  logic [rate_servo_pkg::BEAM_W-1:0]               beam_idx_i,
    input  logic                                            count_we_i,
    input  logic [rate_servo_pkg::WB_DAT_W-1:0]             count_i,
    input  logic                                            step_en_i,
    input  logic                                            commit_i,
    input  logic [rate_servo_pkg::WB_DAT_W-1:0]             kp_i,
    input  logic [rate_servo_pkg::WB_DAT_W-1:0]             target_i,
    output logic [NBEAMS-1:0][rate_servo_pkg::WB_DAT_W-1:0] counts_o,
    output logic [NBEAMS-1:0][rate_servo_pkg::THRESH_W-1:0] thresh_o,
    output logic [rate_servo_pkg::THRESH_W-1:0]             next_thresh_o
);
    import rate_servo_pkg::*;

    localparam int EXT_W = WB_DAT_W + 1;   // One spare bit, no wrap in compares
    localparam logic [THRESH_W-1:0] START_V = THRESH_W'(START_THRESH);

    logic [NBEAMS-1:0][WB_DAT_W-1:0] counts_q;
    logic [NBEAMS-1:0][THRESH_W-1:0] thresh_q;   // Applied in the trigger
    logic [NBEAMS-1:0][THRESH_W-1:0] next_q;     // Waiting for the next update
    logic [THRESH_W-1:0]             cur_thr;
    logic [THRESH_W-1:0]             stepped;
    logic [EXT_W-1:0]                cnt_x;
    logic [EXT_W-1:0]                tgt_x;
    logic [EXT_W-1:0]                up_sum;

    //////////////////////////////
    // Saturating step for the selected beam
    always_comb begin
        cur_thr = thresh_q[beam_idx_i];
        cnt_x   = EXT_W'(counts_q[beam_idx_i]);
        tgt_x   = EXT_W'(target_i);
        up_sum  = EXT_W'(cur_thr) + EXT_W'(kp_i);
        stepped = cur_thr;                                   // Inside the band, hold
        if (cnt_x > tgt_x + EXT_W'(COUNT_MARGIN))            // Too many triggers, raise
            stepped = (up_sum > EXT_W'(THRESH_MAX)) ? THRESH_MAX : up_sum[THRESH_W-1:0];
        else if (cnt_x + EXT_W'(COUNT_MARGIN) < tgt_x)       // Too few, lower
            stepped = (kp_i > WB_DAT_W'(cur_thr)) ? '0 : cur_thr - kp_i[THRESH_W-1:0];
    end

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            counts_q <= '0;
            thresh_q <= {NBEAMS{START_V}};
            next_q   <= {NBEAMS{START_V}};
        end else begin
            if (count_we_i) counts_q[beam_idx_i] <= count_i;
            if (step_en_i)  next_q[beam_idx_i]   <= stepped;
            if (commit_i)   thresh_q             <= next_q;  // All beams at once
        end
    end

    assign counts_o      = counts_q;
    assign thresh_o      = thresh_q;
    assign next_thresh_o = next_q[beam_idx_i];

    // Sequencer beam counter must stay inside the bank
    a_beam_range : assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        (count_we_i || step_en_i || commit_i) |-> (beam_idx_i < NBEAMS));

endmodule

/* hw/trig_bus_master.sv */
module trig_bus_master (
    input  logic                                wb_clk_i,
    input  logic                                arst_n_i,
    input  logic                                cmd_valid_i,
    input  rate_servo_pkg::trig_cmd_t           cmd_i,
    input  logic                                trig_ack_i,
    input  logic [rate_servo_pkg::WB_DAT_W-1:0] trig_dat_i,
    output logic                                cmd_done_o,
    output logic [rate_servo_pkg::WB_DAT_W-1:0] rsp_dat_o,
    output rate_servo_pkg::wb_req_t             trig_req_o
);
    import rate_servo_pkg::*;

    // DONE keeps a still-valid command from being taken twice
    typedef enum logic [1:0] {M_IDLE, M_BUSY, M_DONE} mst_state_e;

    mst_state_e          state_q;
    trig_cmd_t           cmd_q;     // Latched access
    logic [WB_DAT_W-1:0] rsp_q;
    logic                active;

    always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) state_q <= M_IDLE;
        else begin
            unique case (state_q)
                M_IDLE:  if (cmd_valid_i) state_q <= M_BUSY;
                M_BUSY:  if (trig_ack_i) state_q <= M_DONE;   // No timeout, waits forever
                default: state_q <= M_IDLE;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (state_q == M_IDLE && cmd_valid_i) cmd_q <= cmd_i;
        if (state_q == M_BUSY && trig_ack_i)  rsp_q <= trig_dat_i;  // Read data on ack edge
    end

    assign active     = (state_q == M_BUSY);
    assign cmd_done_o = (state_q == M_DONE);
    assign rsp_dat_o  = rsp_q;
    assign trig_req_o = '{cyc: active, stb: active, we: cmd_q.we, adr: cmd_q.adr,
                          dat: cmd_q.dat, sel: {WB_SEL_W{active}}};

    a_stb_hold : assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
        (trig_req_o.stb && !trig_ack_i) |=> trig_req_o.stb);

endmodule

/* hw/rate_servo_top.sv */
module rate_servo_top #(
    parameter int NBEAMS       = 4,
    parameter int START_THRESH = 3500,
    parameter int START_TARGET = 100,
    parameter int START_KP     = 1,
    parameter int COUNT_MARGIN = 10,
    parameter int BOOT_CYCLES  = 31
) (
    input  logic                                wb_clk_i,
    input  logic                                arst_n_i,
    // Software slave port
    input  logic                                wb_cyc_i,
    input  logic                                wb_stb_i,
    input  logic                                wb_we_i,
    input  logic [rate_servo_pkg::WB_ADR_W-1:0] wb_adr_i,
    input  logic [rate_servo_pkg::WB_DAT_W-1:0] wb_dat_i,
    input  logic [rate_servo_pkg::WB_SEL_W-1:0] wb_sel_i,
    output logic                                wb_ack_o,
    output logic [rate_servo_pkg::WB_DAT_W-1:0] wb_dat_o,
    // Trigger master port
    output rate_servo_pkg::wb_req_t             trig_req_o,
    input  logic                                trig_ack_i,
    input  logic [rate_servo_pkg::WB_DAT_W-1:0] trig_dat_i
);
    import rate_servo_pkg::*;

    logic [WB_DAT_W-1:0]             kp, target;
    logic [NBEAMS-1:0][WB_DAT_W-1:0] counts;
    logic [NBEAMS-1:0][THRESH_W-1:0] thresh;
    logic [THRESH_W-1:0]             next_thresh;
    logic [BEAM_W-1:0]               beam_idx;
    logic                            count_we, step_en, commit;
    logic                            cmd_valid, cmd_done;
    trig_cmd_t                       cmd;
    logic [WB_DAT_W-1:0]             rsp_dat;     // Poll status and beam counts

    //////////////////////////////
    // Input side
    servo_csr_slave #(.NBEAMS(NBEAMS), .START_KP(START_KP), .START_TARGET(START_TARGET)) u_csr (
        .wb_clk_i, .arst_n_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_sel_i,
        .counts_i(counts), .thresh_i(thresh), .wb_ack_o, .wb_dat_o,
        .kp_o(kp), .target_o(target));

    // Processing
    rate_loop_seq #(.NBEAMS(NBEAMS), .BOOT_CYCLES(BOOT_CYCLES)) u_seq (
        .wb_clk_i, .arst_n_i, .cmd_done_i(cmd_done), .rsp_dat_i(rsp_dat),
        .next_thresh_i(next_thresh), .cmd_valid_o(cmd_valid), .cmd_o(cmd),
        .beam_idx_o(beam_idx), .count_we_o(count_we), .step_en_o(step_en), .commit_o(commit));

    threshold_bank #(.NBEAMS(NBEAMS), .START_THRESH(START_THRESH),
                     .COUNT_MARGIN(COUNT_MARGIN)) u_bank (
        .wb_clk_i, .arst_n_i, .beam_idx_i(beam_idx), .count_we_i(count_we), .count_i(rsp_dat),
        .step_en_i(step_en), .commit_i(commit), .kp_i(kp), .target_i(target),
        .counts_o(counts), .thresh_o(thresh), .next_thresh_o(next_thresh));

    // Output side
    trig_bus_master u_mst (
        .wb_clk_i, .arst_n_i, .cmd_valid_i(cmd_valid), .cmd_i(cmd), .trig_ack_i, .trig_dat_i,
        .cmd_done_o(cmd_done), .rsp_dat_o(rsp_dat), .trig_req_o);

endmodule

/* tests/servo_checker.sv */
module servo_checker #(
    parameter int NBEAMS       = 4,
    parameter int START_THRESH = 3500,
    parameter int START_KP     = 1,
    parameter int START_TARGET = 100,
    parameter int COUNT_MARGIN = 10
) (
    input  logic                                wb_clk_i,
    input  logic                                arst_n_i,
    input  rate_servo_pkg::wb_req_t             trig_req_i,
    input  logic                                trig_ack_i,
    input  logic [rate_servo_pkg::WB_DAT_W-1:0] trig_dat_i,
    input  rate_servo_pkg::wb_req_t             sw_req_i,    // Software bus into the slave
    input  logic                                sw_ack_i,
    output int                                  passes_o,
    output int                                  fails_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import rate_servo_pkg::*;

    typedef struct packed {
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
    } wr_exp_t;

    wr_exp_t exp_q[$];                // Trigger writes still to come
    longint  cur_m [NBEAMS];          // Thresholds live in the trigger
    longint  nxt_m [NBEAMS];          // Sent on the next pass
    longint  kp_m   = START_KP;
    longint  tgt_m  = START_TARGET;
    int      errs   = 0;              // Mismatches in this pass
    int      passes = 0;
    int      fails  = 0;

    // Threshold rule: raise above the band, lower below it, clip to 18 bits
    function automatic longint next_thresh(longint cur, longint cnt);
        if (cnt > tgt_m + COUNT_MARGIN)
            return (cur + kp_m > longint'(THRESH_MAX)) ? longint'(THRESH_MAX) : cur + kp_m;
        if (cnt + COUNT_MARGIN < tgt_m)
            return (kp_m > cur) ? 0 : cur - kp_m;
        return cur;
    endfunction

    // One full pass of writes: thresholds, enables, update, start
    function automatic void queue_pass();
        for (int b = 0; b < NBEAMS; b++) exp_q.push_back('{TRIG_BEAM_BASE + b, nxt_m[b]});
        for (int b = 0; b < NBEAMS; b++) exp_q.push_back('{TRIG_CE_BASE + b, 32'd1});
        exp_q.push_back('{TRIG_CTRL_ADR, CMD_UPDATE});
        exp_q.push_back('{TRIG_CTRL_ADR, CMD_START});
    endfunction

    initial begin
        for (int b = 0; b < NBEAMS; b++) begin
            cur_m[b] = START_THRESH;
            nxt_m[b] = START_THRESH;
        end
        queue_pass();                 // Boot pass sends the start values
    end

    always @(posedge wb_clk_i) begin
        wr_exp_t e;
        int      b;
        if (arst_n_i) begin
            if (trig_req_i.cyc !== trig_req_i.stb) begin
                $display("Trigger cyc and stb differ: cyc %b stb %b",
                         trig_req_i.cyc, trig_req_i.stb);
                errs++;
            end
            // Track software writes to K_P and target
            if (sw_ack_i && sw_req_i.we && !sw_req_i.adr[CSR_COUNT_BIT]
                && !sw_req_i.adr[CSR_THRESH_BIT]) begin
                if (sw_req_i.adr[CSR_TARGET_BIT]) tgt_m = sw_req_i.dat;
                else kp_m = sw_req_i.dat;
            end
            if (trig_req_i.cyc && trig_req_i.stb && trig_ack_i) begin
                if (trig_req_i.sel !== '1) begin
                    $display("Trigger access to %h without all byte lanes selected: sel %h",
                             trig_req_i.adr, trig_req_i.sel);
                    errs++;
                end
                if (trig_req_i.we) begin
                    if (exp_q.size() == 0) begin
                        $display("Trigger write %h <= %h arrived when no write was expected",
                                 trig_req_i.adr, trig_req_i.dat);
                        errs++;
                    end else begin
                        e = exp_q.pop_front();
                        if (trig_req_i.adr != e.adr || trig_req_i.dat != e.dat) begin
                            $display("FAIL pass %0d trigger write: expected %h <= %h, actual %h <= %h",
                                     passes, e.adr, e.dat, trig_req_i.adr, trig_req_i.dat);
                            errs++;
                        end
                    end
                    if (trig_req_i.adr == TRIG_CTRL_ADR && trig_req_i.dat == CMD_UPDATE)
                        cur_m = nxt_m;        // Trigger loads the new set
                    if (trig_req_i.adr == TRIG_CTRL_ADR && trig_req_i.dat == CMD_START) begin
                        $display("pass %0d trigger writes checked, %0d mismatches", passes, errs);
                        if (errs != 0) fails++;
                        passes++;
                        errs = 0;
                    end
                end else if (trig_req_i.adr >= TRIG_BEAM_BASE
                             && trig_req_i.adr < TRIG_BEAM_BASE + NBEAMS) begin
                    b = int'(trig_req_i.adr - TRIG_BEAM_BASE);
                    nxt_m[b] = next_thresh(cur_m[b], longint'(trig_dat_i));
                    if (b == NBEAMS - 1) queue_pass();   // Last count, step done next
                end else if (trig_req_i.adr != TRIG_CTRL_ADR) begin
                    $display("Trigger read from an address outside the map: %h", trig_req_i.adr);
                    errs++;
                end
            end
        end
    end

    assign passes_o = passes;
    assign fails_o  = fails + int'(errs != 0);   // Pass still open counts once

endmodule

/* tests/tb_rate_servo.sv */
module tb_rate_servo;
    timeunit 1ns;
    timeprecision 100ps;
    import rate_servo_pkg::*;

    localparam int NBEAMS  = 4;
    localparam int NROWS   = 4;
    localparam int NSW     = 22;
    localparam int NGRP    = 4;       // Stalled polls with software traffic
    localparam int NPASS   = 5;
    localparam int TIMEOUT = 5000;    // Cycles per wait

    typedef struct packed {
        logic [3:0]          grp;     // Which stalled poll runs the row
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [WB_DAT_W-1:0] dat;
        logic [WB_DAT_W-1:0] exp;
    } sw_row_t;

    logic                wb_clk_i  = 1'b0;
    logic                arst_n_i  = 1'b0;
    wb_req_t             sw_req    = '0;
    logic                sw_ack;
    logic [WB_DAT_W-1:0] sw_dat;
    wb_req_t             trig_req;
    logic                trig_ack  = 1'b0;
    logic [WB_DAT_W-1:0] trig_dat  = '0;
    int                  seed      = 32'h22b2_04f6;
    int                  hold_pass = 0;     // Poll of this pass is stalled
    logic                stalled   = 1'b0;
    int                  starts    = 0;
    int                  polls     = 0;
    int                  wait_cnt  = 0;     // Ack delay left
    int                  sw_errs   = 0;
    int                  sw_tests  = 0;
    int                  passes;
    int                  chk_fails;

    // Beam counts per pass
    int count_tab [NROWS][NBEAMS] = '{'{500, 50, 95, 110}, '{0, 300, 100, 89},
        '{1000, 0, 200, 200}, '{1000, 0, 200, 200}};

    sw_row_t sw_tab [NSW] = '{
        '{4'd0, 1'b0, 22'h000, 32'd0, 32'd1},       // Reset K_P
        '{4'd0, 1'b0, 22'h001, 32'd0, 32'd100},
        '{4'd0, 1'b0, 22'h200, 32'd0, 32'd3500},
        '{4'd0, 1'b0, 22'h201, 32'd0, 32'd3500},
        '{4'd0, 1'b0, 22'h202, 32'd0, 32'd3500},
        '{4'd0, 1'b0, 22'h203, 32'd0, 32'd3500},
        '{4'd0, 1'b0, 22'h100, 32'd0, 32'd0},       // No counts read yet
        '{4'd1, 1'b0, 22'h100, 32'd0, 32'd500},     // Counts of pass 0
        '{4'd1, 1'b0, 22'h101, 32'd0, 32'd50},
        '{4'd1, 1'b0, 22'h102, 32'd0, 32'd95},
        '{4'd1, 1'b0, 22'h103, 32'd0, 32'd110},
        '{4'd1, 1'b0, 22'h200, 32'd0, 32'd3501},
        '{4'd1, 1'b0, 22'h201, 32'd0, 32'd3499},
        '{4'd1, 1'b1, 22'h001, 32'd200, 32'd0},     // New target
        '{4'd1, 1'b1, 22'h000, 32'd5, 32'd0},
        '{4'd1, 1'b0, 22'h001, 32'd0, 32'd200},
        '{4'd1, 1'b0, 22'h000, 32'd0, 32'd5},
        '{4'd2, 1'b0, 22'h200, 32'd0, 32'd3496},
        '{4'd2, 1'b0, 22'h201, 32'd0, 32'd3504},
        '{4'd2, 1'b1, 22'h000, 32'h4_0000, 32'd0},  // Large gain for saturation
        '{4'd3, 1'b0, 22'h200, 32'd0, 32'h3_ffff},
        '{4'd3, 1'b0, 22'h201, 32'd0, 32'd0}};

    always #2 wb_clk_i = ~wb_clk_i;

    rate_servo_top #(.NBEAMS(NBEAMS)) DUT (
        .wb_clk_i, .arst_n_i, .wb_cyc_i(sw_req.cyc), .wb_stb_i(sw_req.stb), .wb_we_i(sw_req.we),
        .wb_adr_i(sw_req.adr), .wb_dat_i(sw_req.dat), .wb_sel_i(sw_req.sel),
        .wb_ack_o(sw_ack), .wb_dat_o(sw_dat), .trig_req_o(trig_req),
        .trig_ack_i(trig_ack), .trig_dat_i(trig_dat));

    servo_checker #(.NBEAMS(NBEAMS)) u_chk (
        .wb_clk_i, .arst_n_i, .trig_req_i(trig_req), .trig_ack_i(trig_ack),
        .trig_dat_i(trig_dat), .sw_req_i(sw_req), .sw_ack_i(sw_ack),
        .passes_o(passes), .fails_o(chk_fails));

    //////////////////////////////
    // Trigger model
    always @(posedge wb_clk_i) begin
        #1;
        trig_ack = 1'b0;
        stalled  = trig_req.stb && !trig_req.we && trig_req.adr == TRIG_CTRL_ADR
                   && starts == hold_pass + 1;
        if (trig_req.cyc && trig_req.stb && !stalled) begin
            if (wait_cnt > 0) wait_cnt--;
            else begin
                trig_ack = 1'b1;
                trig_dat = '0;
                wait_cnt = $unsigned($random(seed)) % 8;      // Next access delay
                if (trig_req.we && trig_req.adr == TRIG_CTRL_ADR && trig_req.dat == CMD_START)
                    starts++;
                else if (!trig_req.we && trig_req.adr == TRIG_CTRL_ADR) begin
                    trig_dat = WB_DAT_W'(polls == 2);           // Done on third poll
                    polls    = (polls == 2) ? 0 : polls + 1;
                end else if (!trig_req.we)
                    trig_dat = count_tab[(starts - 1) % NROWS][trig_req.adr[1:0]];
            end
        end
    end

    task automatic csr_access(input sw_row_t row, input int idx);
        int edges = 0;
        @(posedge wb_clk_i);
        #1 sw_req = '{cyc: 1'b1, stb: 1'b1, we: row.we, adr: row.adr, dat: row.dat, sel: '1};
        do begin
            @(posedge wb_clk_i);
            edges++;
        end while (!sw_ack && edges < TIMEOUT);
        sw_tests++;
        if (!sw_ack) begin
            $display("sw access %0d got no ack from the slave", idx);
            sw_errs++;
        end else if (edges != 3) begin
            $display("sw access %0d acked %0d edges after the request instead of 3", idx, edges);
            sw_errs++;
        end else if (!row.we && sw_dat !== row.exp) begin
            $display("FAIL sw access %0d: expected %0d actual %0d", idx, row.exp, sw_dat);
            sw_errs++;
        end else
            $display("sw access %0d ok", idx);
        #1 sw_req = '0;
    endtask

    initial begin
        int n;
        repeat (10) @(posedge wb_clk_i);
        sw_tests++;
        if (sw_ack !== 1'b0 || trig_req.cyc !== 1'b0 || trig_req.stb !== 1'b0) begin
            $display("Slave ack or trigger cyc and stb not low while in reset");
            sw_errs++;
        end else
            $display("reset outputs ok");
        #1 arst_n_i = 1'b1;
        for (int g = 0; g < NGRP; g++) begin
            n = 0;
            repeat (2) @(posedge wb_clk_i);   // Let the model see the new hold
            while (!stalled && n < TIMEOUT) begin
                @(posedge wb_clk_i);
                n++;
            end
            if (!stalled) begin
                $display("Loop never reached the poll of pass %0d", g);
                sw_errs++;
            end
            for (int i = 0; i < NSW; i++) if (sw_tab[i].grp == g) csr_access(sw_tab[i], i);
            hold_pass = g + 1;
        end
        n = 0;
        while (passes < NPASS && n < TIMEOUT) begin
            @(posedge wb_clk_i);
            n++;
        end
        if (passes < NPASS) begin
            $display("Checker saw only %0d of %0d trigger passes", passes, NPASS);
            sw_errs++;
        end
        $display("Counts: %0d tests, %0d failed", sw_tests + passes, sw_errs + chk_fails);
        if (sw_errs + chk_fails == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* filelist.f */
hw/rate_servo_pkg.sv
hw/servo_csr_slave.sv
hw/rate_loop_seq.sv
hw/threshold_bank.sv
hw/trig_bus_master.sv
hw/rate_servo_top.sv
tests/servo_checker.sv
tests/tb_rate_servo.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module tb_rate_servo -Mdir build
	./build/Vtb_rate_servo | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null

clean:
	rm -rf build
